//--- hw/regfile_defs.svh
// ----------------------------
// Register file parameters
// Bus and register widths, field widths, reset values
// ----------------------------
`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// Bus widths
`define RF_AXI_ADDR_W   8
`define RF_AXI_DATA_W   32
`define RF_REG_W        16

// Field widths
`define RF_PHY_ADDR_W   5
`define RF_PKT_LEN_W    2
`define RF_IDLE_LEN_W   16
`define RF_MEM_ADDR_W   15
`define RF_DATA_SEL_W   7
`define RF_PKT_DATA_W   9

// ----------------------------
// Reset values
// ----------------------------
`define RF_PHY_ADDR_RST 5'h1f
// broadcast_mode and opendrain_mode come up set
`define RF_MODE_RST     5'h14
`define RF_IDLE_LEN_RST 16'h7fff

`endif

//--- hw/regfile_pkg.sv
// ----------------------------
// Register file types
// Register index, controller state, bus response
// ----------------------------
package regfile_pkg;

    // Word index, byte offset is 4 x index
    typedef enum logic [3:0] {
        PHY_ADDR      = 4'd0,
        MODE          = 4'd1,
        CAPTURE       = 4'd2,
        IDLE_LEN      = 4'd3,
        MDIO_MEM_ADDR = 4'd4,
        MDIO_DATA_SEL = 4'd5,
        MDIO_PKT_DATA = 4'd6,
        MDIO_READ     = 4'd7
    } reg_index_e;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        WRITE_RESP = 2'd1,
        READ_DATA  = 2'd2
    } axil_state_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

endpackage

//--- hw/reg_access_if.sv
// ----------------------------
// Register access interface
// Bus controller to config bank and command bank
// ----------------------------
`timescale 1ns/1ps
`include "regfile_defs.svh"

interface reg_access_if;
    import regfile_pkg::*;

    logic                   wr_en;
    reg_index_e             index;
    logic [`RF_REG_W-1:0]   wdata;
    // Each bank drives zero outside its own indices
    logic [`RF_REG_W-1:0]   cfg_rdata;
    logic [`RF_REG_W-1:0]   cmd_rdata;

    modport ctrl (
        output wr_en,
        output index,
        output wdata,
        input  cfg_rdata,
        input  cmd_rdata
    );

    modport cfg (
        input  wr_en,
        input  index,
        input  wdata,
        output cfg_rdata
    );

    modport cmd (
        input  wr_en,
        input  index,
        input  wdata,
        output cmd_rdata
    );

endinterface

//--- hw/axil_reg_ctrl.sv
// ----------------------------
// AXI4-Lite slave controller
// Index decode, write strobe, read data merge,
// single outstanding transaction
// ----------------------------
`timescale 1ns/1ps
`include "regfile_defs.svh"

module axil_reg_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,

    input  logic [`RF_AXI_ADDR_W-1:0]   awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`RF_AXI_DATA_W-1:0]   wdata,
    input  logic [`RF_AXI_DATA_W/8-1:0] wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic                        bvalid,
    output regfile_pkg::axil_resp_e     bresp,
    input  logic                        bready,

    input  logic [`RF_AXI_ADDR_W-1:0]   araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic                        rvalid,
    output logic [`RF_AXI_DATA_W-1:0]   rdata,
    output regfile_pkg::axil_resp_e     rresp,
    input  logic                        rready,

    reg_access_if.ctrl                  regs
);
    import regfile_pkg::*;

    axil_state_e                state_q;
    axil_state_e                state_d;
    axil_resp_e                 bresp_q;
    axil_resp_e                 rresp_q;
    logic [`RF_REG_W-1:0]       rdata_q;

    logic                       in_idle;
    logic                       wr_pair;
    logic                       wr_hs;
    logic                       rd_hs;
    logic [`RF_AXI_ADDR_W-1:0]  sel_addr;
    logic                       mapped;
    logic [`RF_REG_W-1:0]       merged_rdata;

    // ----------------------------
    // Handshake and decode
    // ----------------------------
    assign in_idle = (state_q == IDLE);
    assign wr_pair = awvalid & wvalid;

    // Writes win when both channels are waiting
    assign awready = in_idle & wr_pair;
    assign wready  = in_idle & wr_pair;
    assign arready = in_idle & arvalid & ~wr_pair;

    assign wr_hs = awready;
    assign rd_hs = arready;

    assign sel_addr = wr_pair ? awaddr : araddr;

    // Index 8 and up, or any address bit above the index field, is unmapped
    assign mapped = ~|sel_addr[`RF_AXI_ADDR_W-1:5];

    // Write strobe ignored and the full register is replaced
    assign regs.wr_en = wr_hs & mapped;
    assign regs.index = reg_index_e'(sel_addr[5:2]);
    assign regs.wdata = wdata[`RF_REG_W-1:0];

    assign merged_rdata = regs.cfg_rdata | regs.cmd_rdata;

    // ----------------------------
    // State machine
    // ----------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (wr_hs) begin
                    state_d = WRITE_RESP;
                end else if (rd_hs) begin
                    state_d = READ_DATA;
                end
            end
            WRITE_RESP: begin
                if (bready) begin
                    state_d = IDLE;
                end
            end
            READ_DATA: begin
                if (rready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            bresp_q <= OKAY;
            rresp_q <= OKAY;
        end else begin
            state_q <= state_d;
            if (wr_hs) begin
                bresp_q <= mapped ? OKAY : SLVERR;
            end
            if (rd_hs) begin
                rresp_q <= mapped ? OKAY : SLVERR;
            end
        end
    end

    // Read data captured on the address handshake and held until accepted
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_q <= '0;
        end else if (rd_hs) begin
            rdata_q <= mapped ? merged_rdata : '0;
        end
    end

    assign bvalid = (state_q == WRITE_RESP);
    assign bresp  = bresp_q;
    assign rvalid = (state_q == READ_DATA);
    assign rresp  = rresp_q;
    assign rdata  = {{(`RF_AXI_DATA_W-`RF_REG_W){1'b0}}, rdata_q};

endmodule

//--- hw/cfg_reg_bank.sv
// ----------------------------
// Configuration register bank
// Read/write fields of indices 0 to 5
// ----------------------------
`timescale 1ns/1ps
`include "regfile_defs.svh"

module cfg_reg_bank (
    input  logic                        clk,
    input  logic                        arst_n,
    reg_access_if.cfg                   regs,

    output logic [`RF_PHY_ADDR_W-1:0]   legal_phy_addr,
    output logic [`RF_PHY_ADDR_W-1:0]   legal_phy_addr_mask,
    output logic [`RF_PHY_ADDR_W-1:0]   broadcast_addr,
    output logic                        broadcast_mode,
    output logic                        non_zero_detect,
    output logic                        opendrain_mode,
    output logic                        watchdog_enable,
    output logic                        sync_select,
    output logic                        self_test_mode,
    output logic [`RF_PKT_LEN_W-1:0]    pkt_data_length,
    output logic                        capture_mode,
    output logic                        path96_en,
    output logic [`RF_IDLE_LEN_W-1:0]   pkt_idle_length,
    output logic [`RF_MEM_ADDR_W-1:0]   mdio_memory_addr,
    output logic [`RF_DATA_SEL_W-1:0]   mdio_data_sel
);
    import regfile_pkg::*;

    logic [4:0] mode_q;

    // ----------------------------
    // Field registers
    // ----------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            legal_phy_addr      <= `RF_PHY_ADDR_RST;
            legal_phy_addr_mask <= `RF_PHY_ADDR_RST;
            broadcast_addr      <= `RF_PHY_ADDR_RST;
            mode_q              <= `RF_MODE_RST;
            self_test_mode      <= 1'b0;
            pkt_data_length     <= '0;
            capture_mode        <= 1'b0;
            path96_en           <= 1'b1;
            pkt_idle_length     <= `RF_IDLE_LEN_RST;
            mdio_memory_addr    <= '0;
            mdio_data_sel       <= '0;
        end else if (regs.wr_en) begin
            case (regs.index)
                PHY_ADDR: begin
                    legal_phy_addr      <= regs.wdata[14:10];
                    legal_phy_addr_mask <= regs.wdata[9:5];
                    broadcast_addr      <= regs.wdata[4:0];
                end
                MODE: begin
                    mode_q <= regs.wdata[4:0];
                end
                CAPTURE: begin
                    // Bits 2 and 1 belong to the command bank
                    self_test_mode  <= regs.wdata[6];
                    pkt_data_length <= regs.wdata[5:4];
                    capture_mode    <= regs.wdata[3];
                    path96_en       <= regs.wdata[0];
                end
                IDLE_LEN: begin
                    pkt_idle_length <= regs.wdata[`RF_IDLE_LEN_W-1:0];
                end
                MDIO_MEM_ADDR: begin
                    mdio_memory_addr <= regs.wdata[`RF_MEM_ADDR_W-1:0];
                end
                MDIO_DATA_SEL: begin
                    mdio_data_sel <= regs.wdata[`RF_DATA_SEL_W-1:0];
                end
                default: ;
            endcase
        end
    end

    assign broadcast_mode  = mode_q[4];
    assign non_zero_detect = mode_q[3];
    assign opendrain_mode  = mode_q[2];
    assign watchdog_enable = mode_q[1];
    assign sync_select     = mode_q[0];

    // ----------------------------
    // Read words
    // ----------------------------
    always_comb begin
        case (regs.index)
            PHY_ADDR:
                regs.cfg_rdata = {1'b0, legal_phy_addr, legal_phy_addr_mask, broadcast_addr};
            MODE:
                regs.cfg_rdata = {11'b0, mode_q};
            CAPTURE:
                regs.cfg_rdata = {9'b0, self_test_mode, pkt_data_length, capture_mode,
                                  2'b00, path96_en};
            IDLE_LEN:
                regs.cfg_rdata = pkt_idle_length;
            MDIO_MEM_ADDR:
                regs.cfg_rdata = {{(`RF_REG_W-`RF_MEM_ADDR_W){1'b0}}, mdio_memory_addr};
            MDIO_DATA_SEL:
                regs.cfg_rdata = {{(`RF_REG_W-`RF_DATA_SEL_W){1'b0}}, mdio_data_sel};
            default:
                regs.cfg_rdata = '0;
        endcase
    end

endmodule

//--- hw/cmd_status_regs.sv
// ----------------------------
// Command and status registers
// Self-clearing pulses for indices 2 and 7,
// device-loaded packet data at index 6
// ----------------------------
`timescale 1ns/1ps
`include "regfile_defs.svh"

module cmd_status_regs (
    input  logic                        clk,
    input  logic                        arst_n,
    reg_access_if.cmd                   regs,

    input  logic [`RF_PKT_DATA_W-1:0]   mdio_pkt_data,
    input  logic                        mdio_pkt_data_we,

    output logic                        capture_start,
    output logic                        capture_again,
    output logic                        mdio_read_pulse
);
    import regfile_pkg::*;

    logic                       wr_capture;
    logic                       wr_read;
    logic [`RF_PKT_DATA_W-1:0]  pkt_data_q;

    assign wr_capture = regs.wr_en & (regs.index == CAPTURE);
    assign wr_read    = regs.wr_en & (regs.index == MDIO_READ);

    // ----------------------------
    // One-cycle command pulses
    // ----------------------------
    // wr_en lasts a single cycle, so each pulse drops on the next edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            capture_start   <= 1'b0;
            capture_again   <= 1'b0;
            mdio_read_pulse <= 1'b0;
        end else begin
            capture_start   <= wr_capture & regs.wdata[2];
            capture_again   <= wr_capture & regs.wdata[1];
            mdio_read_pulse <= wr_read & regs.wdata[0];
        end
    end

    // Packet data holding register, bus writes have no effect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_data_q <= '0;
        end else if (mdio_pkt_data_we) begin
            pkt_data_q <= mdio_pkt_data;
        end
    end

    // Command bits always read back as zero
    always_comb begin
        if (regs.index == MDIO_PKT_DATA) begin
            regs.cmd_rdata = {{(`RF_REG_W-`RF_PKT_DATA_W){1'b0}}, pkt_data_q};
        end else begin
            regs.cmd_rdata = '0;
        end
    end

endmodule

//--- hw/top_regfile.sv
// ----------------------------
// Register file top level
// AXI4-Lite slave, config bank, command bank
// ----------------------------
`timescale 1ns/1ps
`include "regfile_defs.svh"

module top_regfile (
    input  logic                        clk,
    input  logic                        arst_n,

    // AXI4-Lite slave
    input  logic [`RF_AXI_ADDR_W-1:0]   s_axil_awaddr,
    input  logic                        s_axil_awvalid,
    output logic                        s_axil_awready,
    input  logic [`RF_AXI_DATA_W-1:0]   s_axil_wdata,
    input  logic [`RF_AXI_DATA_W/8-1:0] s_axil_wstrb,
    input  logic                        s_axil_wvalid,
    output logic                        s_axil_wready,
    output logic                        s_axil_bvalid,
    output regfile_pkg::axil_resp_e     s_axil_bresp,
    input  logic                        s_axil_bready,
    input  logic [`RF_AXI_ADDR_W-1:0]   s_axil_araddr,
    input  logic                        s_axil_arvalid,
    output logic                        s_axil_arready,
    output logic                        s_axil_rvalid,
    output logic [`RF_AXI_DATA_W-1:0]   s_axil_rdata,
    output regfile_pkg::axil_resp_e     s_axil_rresp,
    input  logic                        s_axil_rready,

    // Configuration fields
    output logic [`RF_PHY_ADDR_W-1:0]   legal_phy_addr,
    output logic [`RF_PHY_ADDR_W-1:0]   legal_phy_addr_mask,
    output logic [`RF_PHY_ADDR_W-1:0]   broadcast_addr,
    output logic                        broadcast_mode,
    output logic                        non_zero_detect,
    output logic                        opendrain_mode,
    output logic                        watchdog_enable,
    output logic                        sync_select,
    output logic                        self_test_mode,
    output logic [`RF_PKT_LEN_W-1:0]    pkt_data_length,
    output logic                        capture_mode,
    output logic                        path96_en,
    output logic [`RF_IDLE_LEN_W-1:0]   pkt_idle_length,
    output logic [`RF_MEM_ADDR_W-1:0]   mdio_memory_addr,
    output logic [`RF_DATA_SEL_W-1:0]   mdio_data_sel,

    // Commands and device capture
    output logic                        capture_start,
    output logic                        capture_again,
    output logic                        mdio_read_pulse,
    input  logic [`RF_PKT_DATA_W-1:0]   mdio_pkt_data,
    input  logic                        mdio_pkt_data_we
);

    reg_access_if regs ();

    axil_reg_ctrl u_ctrl (
        .clk     (clk),
        .arst_n  (arst_n),
        .awaddr  (s_axil_awaddr),
        .awvalid (s_axil_awvalid),
        .awready (s_axil_awready),
        .wdata   (s_axil_wdata),
        .wstrb   (s_axil_wstrb),
        .wvalid  (s_axil_wvalid),
        .wready  (s_axil_wready),
        .bvalid  (s_axil_bvalid),
        .bresp   (s_axil_bresp),
        .bready  (s_axil_bready),
        .araddr  (s_axil_araddr),
        .arvalid (s_axil_arvalid),
        .arready (s_axil_arready),
        .rvalid  (s_axil_rvalid),
        .rdata   (s_axil_rdata),
        .rresp   (s_axil_rresp),
        .rready  (s_axil_rready),
        .regs    (regs.ctrl)
    );

    cfg_reg_bank u_cfg (
        .clk                 (clk),
        .arst_n              (arst_n),
        .regs                (regs.cfg),
        .legal_phy_addr      (legal_phy_addr),
        .legal_phy_addr_mask (legal_phy_addr_mask),
        .broadcast_addr      (broadcast_addr),
        .broadcast_mode      (broadcast_mode),
        .non_zero_detect     (non_zero_detect),
        .opendrain_mode      (opendrain_mode),
        .watchdog_enable     (watchdog_enable),
        .sync_select         (sync_select),
        .self_test_mode      (self_test_mode),
        .pkt_data_length     (pkt_data_length),
        .capture_mode        (capture_mode),
        .path96_en           (path96_en),
        .pkt_idle_length     (pkt_idle_length),
        .mdio_memory_addr    (mdio_memory_addr),
        .mdio_data_sel       (mdio_data_sel)
    );

    cmd_status_regs u_cmd (
        .clk              (clk),
        .arst_n           (arst_n),
        .regs             (regs.cmd),
        .mdio_pkt_data    (mdio_pkt_data),
        .mdio_pkt_data_we (mdio_pkt_data_we),
        .capture_start    (capture_start),
        .capture_again    (capture_again),
        .mdio_read_pulse  (mdio_read_pulse)
    );

endmodule

//--- verification/tb_top_regfile.sv
// ------------------------------
// Directed testbench for the register file
// AXI4-Lite write and read tasks, shadow register model,
// pulse counters and the closing report
// ------------------------------
`timescale 1ns/1ps
`include "regfile_defs.svh"

module tb_top_regfile;
    import regfile_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic clk;
    logic arst_n;
    logic [`RF_AXI_ADDR_W-1:0] awaddr;
    logic [`RF_AXI_ADDR_W-1:0] araddr;
    logic [`RF_AXI_DATA_W-1:0] wdata;
    logic [`RF_AXI_DATA_W-1:0] rdata;
    logic [3:0] wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    axil_resp_e bresp;
    axil_resp_e rresp;
    logic [`RF_PHY_ADDR_W-1:0] legal_phy_addr, legal_phy_addr_mask, broadcast_addr;
    logic broadcast_mode, non_zero_detect, opendrain_mode, watchdog_enable, sync_select;
    logic self_test_mode, capture_mode, path96_en;
    logic [`RF_PKT_LEN_W-1:0] pkt_data_length;
    logic [`RF_IDLE_LEN_W-1:0] pkt_idle_length;
    logic [`RF_MEM_ADDR_W-1:0] mdio_memory_addr;
    logic [`RF_DATA_SEL_W-1:0] mdio_data_sel;
    logic capture_start, capture_again, mdio_read_pulse;
    logic [`RF_PKT_DATA_W-1:0] mdio_pkt_data;
    logic mdio_pkt_data_we;

    // Expected contents of indices 0 to 7
    logic [15:0] model [8];
    integer seed;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    int start_cnt = 0;
    int again_cnt = 0;
    int read_cnt = 0;

    top_regfile dut (
        .clk(clk), .arst_n(arst_n),
        .s_axil_awaddr(awaddr), .s_axil_awvalid(awvalid), .s_axil_awready(awready),
        .s_axil_wdata(wdata), .s_axil_wstrb(wstrb), .s_axil_wvalid(wvalid),
        .s_axil_wready(wready), .s_axil_bvalid(bvalid), .s_axil_bresp(bresp),
        .s_axil_bready(bready), .s_axil_araddr(araddr), .s_axil_arvalid(arvalid),
        .s_axil_arready(arready), .s_axil_rvalid(rvalid), .s_axil_rdata(rdata),
        .s_axil_rresp(rresp), .s_axil_rready(rready),
        .legal_phy_addr(legal_phy_addr), .legal_phy_addr_mask(legal_phy_addr_mask),
        .broadcast_addr(broadcast_addr), .broadcast_mode(broadcast_mode),
        .non_zero_detect(non_zero_detect), .opendrain_mode(opendrain_mode),
        .watchdog_enable(watchdog_enable), .sync_select(sync_select),
        .self_test_mode(self_test_mode), .pkt_data_length(pkt_data_length),
        .capture_mode(capture_mode), .path96_en(path96_en),
        .pkt_idle_length(pkt_idle_length), .mdio_memory_addr(mdio_memory_addr),
        .mdio_data_sel(mdio_data_sel), .capture_start(capture_start),
        .capture_again(capture_again), .mdio_read_pulse(mdio_read_pulse),
        .mdio_pkt_data(mdio_pkt_data), .mdio_pkt_data_we(mdio_pkt_data_we)
    );

    always #2 clk = ~clk;

    // Count cycles each pulse is high
    always @(negedge clk) begin
        if (capture_start) start_cnt <= start_cnt + 1;
        if (capture_again) again_cnt <= again_cnt + 1;
        if (mdio_read_pulse) read_cnt <= read_cnt + 1;
    end

    // ------------------------------
    // Register map rules
    // ------------------------------
    function automatic logic [15:0] reg_mask(input logic [3:0] idx);
        case (idx)
            4'd0: return 16'h7fff;
            4'd1: return 16'h001f;
            4'd2: return 16'h0079;
            4'd3: return 16'hffff;
            4'd4: return 16'h7fff;
            4'd5: return 16'h007f;
            default: return 16'h0000;
        endcase
    endfunction

    function automatic logic [15:0] reset_value(input logic [3:0] idx);
        case (idx)
            4'd0: return 16'h7fff;
            4'd1: return 16'h0014;
            4'd2: return 16'h0001;
            4'd3: return 16'h7fff;
            default: return 16'h0000;
        endcase
    endfunction

    function automatic logic [7:0] byte_addr(input logic [3:0] idx);
        return {2'b00, idx, 2'b00};
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("Fail %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
        timeouts++;
    endtask

    // ------------------------------
    // Bus tasks
    // ------------------------------
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input int delay, output logic [1:0] resp);
        int n;
        resp = 2'b11;
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        if (n >= WAIT_LIMIT) begin
            report_timeout("awready and wready");
            return;
        end
        n = 0;
        @(negedge clk);
        while (!bvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            report_timeout("bvalid");
            return;
        end
        resp = bresp;
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            check_eq(32'(bvalid), 32'd1, "bvalid held under back-pressure");
            check_eq(32'(bresp), 32'(resp), "bresp stable under back-pressure");
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
        check_eq(32'(bvalid), 32'd0, "bvalid dropped after accept");
    endtask

    task automatic axil_read(input logic [7:0] addr, input int delay,
                             output logic [31:0] data, output logic [1:0] resp);
        int n;
        data = '0;
        resp = 2'b11;
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        arvalid <= 1'b0;
        if (n >= WAIT_LIMIT) begin
            report_timeout("arready");
            return;
        end
        n = 0;
        @(negedge clk);
        while (!rvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            report_timeout("rvalid");
            return;
        end
        data = rdata;
        resp = rresp;
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            check_eq(32'(rvalid), 32'd1, "rvalid held under back-pressure");
            check_eq(rdata, data, "rdata stable under back-pressure");
            check_eq(32'(rresp), 32'(resp), "rresp stable under back-pressure");
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        check_eq(32'(rvalid), 32'd0, "rvalid dropped after accept");
    endtask

    task automatic write_reg(input logic [3:0] idx, input logic [15:0] data, input int delay);
        logic [1:0] resp;
        axil_write(byte_addr(idx), {16'h0000, data}, delay, resp);
        check_eq(32'(resp), 32'(OKAY), $sformatf("bresp index %0d", idx));
        // Index 6 is loaded only from the device side
        if (idx != 4'd6) model[idx[2:0]] = data & reg_mask(idx);
    endtask

    task automatic read_and_compare(input logic [3:0] idx, input int delay);
        logic [31:0] data;
        logic [1:0] resp;
        axil_read(byte_addr(idx), delay, data, resp);
        check_eq(32'(resp), 32'(OKAY), $sformatf("rresp index %0d", idx));
        check_eq(data, {16'h0000, model[idx[2:0]]}, $sformatf("rdata index %0d", idx));
    endtask

    task automatic check_fields(input logic [3:0] idx);
        logic [15:0] m;
        m = model[idx[2:0]];
        case (idx)
            4'd0: begin
                check_eq(32'(legal_phy_addr), 32'(m[14:10]), "legal_phy_addr");
                check_eq(32'(legal_phy_addr_mask), 32'(m[9:5]), "legal_phy_addr_mask");
                check_eq(32'(broadcast_addr), 32'(m[4:0]), "broadcast_addr");
            end
            4'd1: check_eq(32'({broadcast_mode, non_zero_detect, opendrain_mode,
                                watchdog_enable, sync_select}), 32'(m[4:0]), "mode fields");
            4'd2: begin
                check_eq(32'(self_test_mode), 32'(m[6]), "self_test_mode");
                check_eq(32'(pkt_data_length), 32'(m[5:4]), "pkt_data_length");
                check_eq(32'(capture_mode), 32'(m[3]), "capture_mode");
                check_eq(32'(path96_en), 32'(m[0]), "path96_en");
            end
            4'd3: check_eq(32'(pkt_idle_length), 32'(m), "pkt_idle_length");
            4'd4: check_eq(32'(mdio_memory_addr), 32'(m[14:0]), "mdio_memory_addr");
            4'd5: check_eq(32'(mdio_data_sel), 32'(m[6:0]), "mdio_data_sel");
            default: ;
        endcase
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic verify_reset_state();
        for (int i = 0; i < 8; i++) model[i] = reset_value(4'(i));
        for (int i = 0; i < 8; i++) read_and_compare(4'(i), 0);
        for (int i = 0; i < 6; i++) check_fields(4'(i));
        check_eq(32'({capture_start, capture_again, mdio_read_pulse}), 32'd0, "pulses after reset");
    endtask

    task automatic random_round_trips();
        logic [31:0] rnd;
        for (int i = 0; i < 6; i++) begin
            repeat (3) begin
                rnd = $random(seed);
                // Upper random bits pick a small back-pressure delay
                write_reg(4'(i), rnd[15:0], int'(rnd[17:16]));
                read_and_compare(4'(i), int'(rnd[19:18]));
                check_fields(4'(i));
            end
        end
    endtask

    task automatic command_pulses();
        int s0;
        int a0;
        int r0;
        s0 = start_cnt;
        a0 = again_cnt;
        r0 = read_cnt;
        write_reg(4'd2, 16'h0006, 0);
        repeat (2) @(negedge clk);
        check_eq(32'(start_cnt - s0), 32'd1, "capture_start pulse cycles");
        check_eq(32'(again_cnt - a0), 32'd1, "capture_again pulse cycles");
        read_and_compare(4'd2, 0);
        check_fields(4'd2);
        write_reg(4'd2, 16'h004d, 0);
        repeat (2) @(negedge clk);
        check_eq(32'(start_cnt - s0), 32'd2, "capture_start second pulse");
        check_eq(32'(again_cnt - a0), 32'd1, "capture_again stays quiet");
        read_and_compare(4'd2, 0);
        check_fields(4'd2);
        write_reg(4'd7, 16'h0001, 0);
        write_reg(4'd7, 16'h0000, 0);
        repeat (2) @(negedge clk);
        check_eq(32'(read_cnt - r0), 32'd1, "mdio_read_pulse cycles");
        read_and_compare(4'd7, 0);
    endtask

    task automatic device_capture();
        logic [31:0] rnd;
        rnd = $random(seed);
        @(posedge clk);
        mdio_pkt_data <= rnd[8:0];
        mdio_pkt_data_we <= 1'b1;
        @(posedge clk);
        mdio_pkt_data_we <= 1'b0;
        model[6] = {7'b0, rnd[8:0]};
        read_and_compare(4'd6, 0);
        write_reg(4'd6, ~model[6], 0);
        read_and_compare(4'd6, 0);
    endtask

    task automatic unmapped_access();
        logic [31:0] rnd;
        logic [31:0] data;
        logic [1:0] resp;
        for (int i = 8; i < 17; i++) begin
            rnd = $random(seed);
            // Last pass uses index 1 with address bit 7 set
            axil_write((i == 16) ? 8'h84 : byte_addr(4'(i)), rnd, 0, resp);
            check_eq(32'(resp), 32'(SLVERR), $sformatf("unmapped bresp pass %0d", i));
            axil_read((i == 16) ? 8'h84 : byte_addr(4'(i)), 0, data, resp);
            check_eq(32'(resp), 32'(SLVERR), $sformatf("unmapped rresp pass %0d", i));
            check_eq(data, 32'd0, $sformatf("unmapped rdata pass %0d", i));
        end
        for (int i = 0; i < 8; i++) read_and_compare(4'(i), 0);
        for (int i = 0; i < 6; i++) check_fields(4'(i));
    endtask

    task automatic held_responses();
        logic [31:0] rnd;
        logic [31:0] data;
        logic [1:0] resp;
        rnd = $random(seed);
        write_reg(4'd3, rnd[15:0], 6);
        read_and_compare(4'd3, 7);
        axil_write(8'h30, rnd, 5, resp);
        check_eq(32'(resp), 32'(SLVERR), "unmapped bresp with back-pressure");
        axil_read(8'h3c, 5, data, resp);
        check_eq(32'(resp), 32'(SLVERR), "unmapped rresp with back-pressure");
        check_eq(data, 32'd0, "unmapped rdata with back-pressure");
    endtask

    initial begin
        seed = 32'h571a_d9dd;
        clk = 1'b0;
        arst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = 4'hf;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        mdio_pkt_data = '0;
        mdio_pkt_data_we = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        verify_reset_state();
        random_round_trips();
        command_pulses();
        device_capture();
        unmapped_access();
        held_responses();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+hw
hw/regfile_pkg.sv
hw/reg_access_if.sv
hw/axil_reg_ctrl.sv
hw/cfg_reg_bank.sv
hw/cmd_status_regs.sv
hw/top_regfile.sv
verification/tb_top_regfile.sv

//--- run_sim.sh
#!/bin/sh
# Build the register file testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_top_regfile \
    -o sim_regfile \
    && ./obj_dir/sim_regfile > sim.log 2>&1 \
    || { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '^>>> PASS$' sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
